/* hdl/upsample_pkg.sv */
package upsample_pkg;

	// Word index of a configuration register, byte address bits 3:2
	typedef enum logic [1:0] {
		UPSTR   = 2'd0,
		UPENDR  = 2'd1,
		UPSRCAR = 2'd2,
		UPDSTAR = 2'd3
	} crf_reg_e;

	// UPSTR layout
	typedef struct packed {
		logic [19:0] rsvd;
		// Number of input samples in the job
		logic [10:0] count;
		logic        go;
	} up_ctrl_t;

	typedef logic signed [15:0] sample_t;

	// PL side write request, held until it lands
	typedef struct packed {
		logic        wrt;
		crf_reg_e    addr;
		logic [31:0] data;
	} pl_wr_t;

	// Interpolated pair, mid goes to addr and cur to addr+1
	typedef struct packed {
		logic        valid;
		sample_t     mid;
		sample_t     cur;
		logic        last;
		logic [15:0] addr;
	} pair_t;

	// One destination word write
	typedef struct packed {
		logic        en;
		logic [15:0] addr;
		sample_t     data;
	} mem_wr_t;

	localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

/* hdl/config_register_file.sv */
`timescale 1ns/10ps

module config_register_file import upsample_pkg::*; #(
	parameter int AXI_DATA_WIDTH = 32,
	parameter int AXI_ADDR_WIDTH = 32
) (
	input  logic                        clk,
	input  logic                        rst_n,
	// Write address channel
	input  logic                        s_axi_awvalid,
	output logic                        s_axi_awready,
	input  logic [AXI_ADDR_WIDTH-1:0]   s_axi_awaddr,
	input  logic [2:0]                  s_axi_awprot,
	// Write data channel
	input  logic                        s_axi_wvalid,
	output logic                        s_axi_wready,
	input  logic [AXI_DATA_WIDTH-1:0]   s_axi_wdata,
	input  logic [AXI_DATA_WIDTH/8-1:0] s_axi_wstrb,
	// Write response channel
	output logic                        s_axi_bvalid,
	input  logic                        s_axi_bready,
	output logic [1:0]                  s_axi_bresp,
	// Read address channel
	input  logic                        s_axi_arvalid,
	output logic                        s_axi_arready,
	input  logic [AXI_ADDR_WIDTH-1:0]   s_axi_araddr,
	input  logic [2:0]                  s_axi_arprot,
	// Read data channel
	output logic                        s_axi_rvalid,
	input  logic                        s_axi_rready,
	output logic [AXI_DATA_WIDTH-1:0]   s_axi_rdata,
	output logic [1:0]                  s_axi_rresp,
	// PL write port
	input  pl_wr_t                      pl_wr,
	output logic                        wbusy,
	// Register view for the controller
	output up_ctrl_t                    cfg_upstr,
	output logic [AXI_DATA_WIDTH-1:0]   cfg_upendr,
	output logic [AXI_DATA_WIDTH-1:0]   cfg_srcar,
	output logic [AXI_DATA_WIDTH-1:0]   cfg_dstar,
	output logic                        irq
);

	// Register array, indexed by crf_reg_e
	logic [AXI_DATA_WIDTH-1:0] regs [4];

	// Single flop drives awready, wready and wbusy
	logic     wr_acc;
	logic     ar_acc;
	logic     pl_land;
	logic     axi_wren;
	logic     axi_rden;
	logic     aw_hit;
	logic     ar_hit;
	crf_reg_e aw_idx;
	crf_reg_e ar_idx;

	assign cfg_upstr  = up_ctrl_t'(regs[UPSTR]);
	assign cfg_upendr = regs[UPENDR];
	assign cfg_srcar  = regs[UPSRCAR];
	assign cfg_dstar  = regs[UPDSTAR];
	// Done flag doubles as the interrupt
	assign irq        = regs[UPENDR][0];

	// Only the first 16 bytes are mapped
	assign aw_hit = (s_axi_awaddr[AXI_ADDR_WIDTH-1:4] == '0);
	assign ar_hit = (s_axi_araddr[AXI_ADDR_WIDTH-1:4] == '0);
	assign aw_idx = crf_reg_e'(s_axi_awaddr[3:2]);
	assign ar_idx = crf_reg_e'(s_axi_araddr[3:2]);

	assign s_axi_awready = wr_acc;
	assign s_axi_wready  = wr_acc;
	// PL side must wait while a PS write lands
	assign wbusy         = wr_acc;
	assign s_axi_bresp   = RESP_OKAY;
	assign s_axi_rresp   = RESP_OKAY;
	assign s_axi_arready = ar_acc;

	assign pl_land  = pl_wr.wrt & ~wbusy;
	assign axi_wren = wr_acc & s_axi_awvalid & s_axi_wvalid;
	assign axi_rden = ar_acc & s_axi_arvalid;

	// Accept a PS write only with both channels present and no response pending
	// A PL request in the same cycle wins, PS retries later
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_acc <= 1'b0;
		end else begin
			wr_acc <= ~wr_acc & s_axi_awvalid & s_axi_wvalid & ~s_axi_bvalid & ~pl_wr.wrt;
		end
	end

	// Register writes, PL first
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else if (pl_land) begin
			regs[pl_wr.addr] <= pl_wr.data;
		end else if (axi_wren && aw_hit) begin
			// Strobes ignored, full word written
			regs[aw_idx] <= s_axi_wdata;
		end
	end

	// Write response, held until bready
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s_axi_bvalid <= 1'b0;
		end else if (s_axi_bvalid) begin
			if (s_axi_bready) begin
				s_axi_bvalid <= 1'b0;
			end
		end else if (axi_wren) begin
			s_axi_bvalid <= 1'b1;
		end
	end

	// arready pulse, blocked while read data waits
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ar_acc <= 1'b0;
		end else begin
			ar_acc <= s_axi_arvalid & ~ar_acc & ~s_axi_rvalid;
		end
	end

	// Read data, no coherence with PL writes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s_axi_rvalid <= 1'b0;
			s_axi_rdata  <= '0;
		end else if (s_axi_rvalid) begin
			if (s_axi_rready) begin
				s_axi_rvalid <= 1'b0;
			end
		end else if (axi_rden) begin
			s_axi_rvalid <= 1'b1;
			// Unmapped addresses read zero
			s_axi_rdata  <= ar_hit ? regs[ar_idx] : '0;
		end
	end

endmodule

/* hdl/upsample_ctrl.sv */
`timescale 1ns/10ps

module upsample_ctrl import upsample_pkg::*; #(
	parameter int MEM_ADDR_WIDTH = 16
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  up_ctrl_t                  cfg_upstr,
	input  logic [31:0]               cfg_srcar,
	input  logic [31:0]               cfg_dstar,
	input  logic                      wbusy,
	input  logic                      last_done,
	output pl_wr_t                    pl_wr,
	output logic                      mem_rd_en,
	output logic [MEM_ADDR_WIDTH-1:0] mem_rd_addr,
	output logic [15:0]               job_dst,
	output logic                      rd_last,
	output logic                      rd_issue
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_CLR_GO,
		S_FETCH,
		S_DRAIN,
		S_POST
	} state_e;

	state_e                    state;
	state_e                    state_nxt;
	logic [10:0]               cnt_q;
	logic [10:0]               rd_cnt;
	logic [MEM_ADDR_WIDTH-1:0] src_q;
	logic [15:0]               dst_q;
	// Spacing toggle, reads only when low
	logic                      phase;
	logic                      pl_land;
	logic                      issue;

	assign pl_land     = pl_wr.wrt & ~wbusy;
	assign issue       = (state == S_FETCH) & ~phase;
	assign mem_rd_en   = issue;
	assign rd_issue    = issue;
	assign rd_last     = issue & (rd_cnt == cnt_q - 11'd1);
	assign mem_rd_addr = src_q + MEM_ADDR_WIDTH'(rd_cnt);
	assign job_dst     = dst_q;

	// PL write request is a level decoded from state
	always_comb begin
		pl_wr = '0;
		case (state)
			S_CLR_GO: begin
				pl_wr.wrt  = 1'b1;
				pl_wr.addr = UPSTR;
				pl_wr.data = 32'd0;
			end
			S_POST: begin
				pl_wr.wrt  = 1'b1;
				pl_wr.addr = UPENDR;
				pl_wr.data = 32'd1;
			end
			default: ;
		endcase
	end

	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE:   if (cfg_upstr.go) state_nxt = S_CLR_GO;
			// Empty job skips straight to done
			S_CLR_GO: if (pl_land) state_nxt = (cnt_q == '0) ? S_POST : S_FETCH;
			S_FETCH:  if (rd_last) state_nxt = S_DRAIN;
			S_DRAIN:  if (last_done) state_nxt = S_POST;
			S_POST:   if (pl_land) state_nxt = S_IDLE;
			default:  state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= S_IDLE;
			cnt_q  <= '0;
			rd_cnt <= '0;
			phase  <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == S_IDLE) begin
				cnt_q  <= cfg_upstr.count;
				rd_cnt <= '0;
				phase  <= 1'b0;
			end else if (state == S_FETCH) begin
				phase <= ~phase;
				if (issue) begin
					rd_cnt <= rd_cnt + 11'd1;
				end
			end
		end
	end

	// Job addresses, latched while idle
	always_ff @(posedge clk) begin
		if (state == S_IDLE) begin
			src_q <= cfg_srcar[MEM_ADDR_WIDTH-1:0];
			dst_q <= cfg_dstar[15:0];
		end
	end

endmodule

/* hdl/interp_stage.sv */
`timescale 1ns/10ps

module interp_stage import upsample_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        rd_issue,
	input  logic        rd_last,
	input  logic [15:0] job_dst,
	input  sample_t     mem_rd_data,
	output pair_t       pair
);

	// Read tags aligned with memory data
	logic               issue_d;
	logic               last_d;
	// Pair index within the job
	logic [10:0]        idx;
	sample_t            prev;
	sample_t            prev_eff;
	logic signed [16:0] sum;
	logic               p_valid;
	logic               p_last;
	sample_t            p_mid;
	sample_t            p_cur;
	logic [15:0]        p_addr;

	// Previous sample counts as zero on the first read of a job
	assign prev_eff = (idx == '0) ? sample_t'(0) : prev;
	assign sum      = 17'(prev_eff) + 17'(mem_rd_data);

	assign pair.valid = p_valid;
	assign pair.mid   = p_mid;
	assign pair.cur   = p_cur;
	assign pair.last  = p_last;
	assign pair.addr  = p_addr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			issue_d <= 1'b0;
			last_d  <= 1'b0;
			idx     <= '0;
			p_valid <= 1'b0;
			p_last  <= 1'b0;
		end else begin
			issue_d <= rd_issue;
			last_d  <= rd_last;
			p_valid <= issue_d;
			p_last  <= issue_d & last_d;
			if (issue_d) begin
				// Restart the index after the final sample
				idx <= last_d ? '0 : idx + 11'd1;
			end
		end
	end

	// Sample payload
	always_ff @(posedge clk) begin
		if (issue_d) begin
			prev   <= mem_rd_data;
			// Arithmetic shift right by one
			p_mid  <= sum[16:1];
			p_cur  <= mem_rd_data;
			p_addr <= job_dst + 16'({idx, 1'b0});
		end
	end

endmodule

/* hdl/store_stage.sv */
`timescale 1ns/10ps

module store_stage import upsample_pkg::*; #(
	parameter int MEM_ADDR_WIDTH = 16
) (
	input  logic    clk,
	input  logic    rst_n,
	input  pair_t   pair,
	output mem_wr_t mem_wr,
	output logic    last_done
);

	// Slot A holds the pair, mid written from here
	logic                      a_valid;
	logic                      a_last;
	sample_t                   a_cur;
	sample_t                   a_mid;
	logic [MEM_ADDR_WIDTH-1:0] a_addr;
	// Slot B holds cur one cycle later
	logic                      b_valid;
	logic                      b_last;
	sample_t                   b_cur;
	logic [MEM_ADDR_WIDTH-1:0] b_addr;

	// Read spacing keeps A and B from being valid together
	always_comb begin
		mem_wr = '0;
		if (a_valid) begin
			mem_wr.en   = 1'b1;
			mem_wr.addr = 16'(a_addr);
			mem_wr.data = a_mid;
		end else if (b_valid) begin
			mem_wr.en   = 1'b1;
			mem_wr.addr = 16'(b_addr);
			mem_wr.data = b_cur;
		end
	end

	assign last_done = b_valid & b_last;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			a_valid <= 1'b0;
			a_last  <= 1'b0;
			b_valid <= 1'b0;
			b_last  <= 1'b0;
		end else begin
			a_valid <= pair.valid;
			a_last  <= pair.valid & pair.last;
			b_valid <= a_valid;
			b_last  <= a_valid & a_last;
		end
	end

	always_ff @(posedge clk) begin
		if (pair.valid) begin
			a_mid  <= pair.mid;
			a_cur  <= pair.cur;
			a_addr <= MEM_ADDR_WIDTH'(pair.addr);
		end
		if (a_valid) begin
			b_cur  <= a_cur;
			// cur lands right after mid
			b_addr <= a_addr + 1'b1;
		end
	end

endmodule

/* hdl/upsampler_top.sv */
`timescale 1ns/10ps

module upsampler_top import upsample_pkg::*; #(
	parameter int AXI_DATA_WIDTH = 32,
	parameter int AXI_ADDR_WIDTH = 32,
	parameter int MEM_ADDR_WIDTH = 16
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        s_axi_awvalid,
	output logic                        s_axi_awready,
	input  logic [AXI_ADDR_WIDTH-1:0]   s_axi_awaddr,
	input  logic [2:0]                  s_axi_awprot,
	input  logic                        s_axi_wvalid,
	output logic                        s_axi_wready,
	input  logic [AXI_DATA_WIDTH-1:0]   s_axi_wdata,
	input  logic [AXI_DATA_WIDTH/8-1:0] s_axi_wstrb,
	output logic                        s_axi_bvalid,
	input  logic                        s_axi_bready,
	output logic [1:0]                  s_axi_bresp,
	input  logic                        s_axi_arvalid,
	output logic                        s_axi_arready,
	input  logic [AXI_ADDR_WIDTH-1:0]   s_axi_araddr,
	input  logic [2:0]                  s_axi_arprot,
	output logic                        s_axi_rvalid,
	input  logic                        s_axi_rready,
	output logic [AXI_DATA_WIDTH-1:0]   s_axi_rdata,
	output logic [1:0]                  s_axi_rresp,
	output logic                        irq,
	// External sample memory
	output logic                        mem_rd_en,
	output logic [MEM_ADDR_WIDTH-1:0]   mem_rd_addr,
	input  sample_t                     mem_rd_data,
	output mem_wr_t                     mem_wr
);

	pl_wr_t                    pl_wr;
	logic                      wbusy;
	up_ctrl_t                  cfg_upstr;
	logic [AXI_DATA_WIDTH-1:0] cfg_srcar;
	logic [AXI_DATA_WIDTH-1:0] cfg_dstar;
	logic [15:0]               job_dst;
	logic                      rd_issue;
	logic                      rd_last;
	pair_t                     pair;
	logic                      last_done;

	config_register_file #(
		.AXI_DATA_WIDTH(AXI_DATA_WIDTH),
		.AXI_ADDR_WIDTH(AXI_ADDR_WIDTH)
	) u_crf (
		.clk(clk), .rst_n(rst_n),
		.s_axi_awvalid(s_axi_awvalid), .s_axi_awready(s_axi_awready),
		.s_axi_awaddr(s_axi_awaddr), .s_axi_awprot(s_axi_awprot),
		.s_axi_wvalid(s_axi_wvalid), .s_axi_wready(s_axi_wready),
		.s_axi_wdata(s_axi_wdata), .s_axi_wstrb(s_axi_wstrb),
		.s_axi_bvalid(s_axi_bvalid), .s_axi_bready(s_axi_bready),
		.s_axi_bresp(s_axi_bresp),
		.s_axi_arvalid(s_axi_arvalid), .s_axi_arready(s_axi_arready),
		.s_axi_araddr(s_axi_araddr), .s_axi_arprot(s_axi_arprot),
		.s_axi_rvalid(s_axi_rvalid), .s_axi_rready(s_axi_rready),
		.s_axi_rdata(s_axi_rdata), .s_axi_rresp(s_axi_rresp),
		.pl_wr(pl_wr), .wbusy(wbusy),
		.cfg_upstr(cfg_upstr), .cfg_upendr(), .cfg_srcar(cfg_srcar),
		.cfg_dstar(cfg_dstar), .irq(irq)
	);

	upsample_ctrl #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_ctrl (
		.clk(clk), .rst_n(rst_n),
		.cfg_upstr(cfg_upstr), .cfg_srcar(cfg_srcar), .cfg_dstar(cfg_dstar),
		.wbusy(wbusy), .last_done(last_done), .pl_wr(pl_wr),
		.mem_rd_en(mem_rd_en), .mem_rd_addr(mem_rd_addr), .job_dst(job_dst),
		.rd_last(rd_last), .rd_issue(rd_issue)
	);

	interp_stage u_interp (
		.clk(clk), .rst_n(rst_n), .rd_issue(rd_issue), .rd_last(rd_last),
		.job_dst(job_dst), .mem_rd_data(mem_rd_data), .pair(pair)
	);

	store_stage #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_store (
		.clk(clk), .rst_n(rst_n), .pair(pair), .mem_wr(mem_wr), .last_done(last_done)
	);

endmodule

/* bench/up_monitor.sv */
`timescale 1ns/10ps

module up_monitor import upsample_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  mem_wr_t mem_wr,
	output int      errors
);

	// Source samples of the job being set up
	sample_t     src_q[$];
	// Expected destination words in write order
	logic [15:0] exp_addr[$];
	sample_t     exp_data[$];
	// Read-back and end of job errors
	int          read_errs = 0;
	// Destination write errors
	int          write_errs = 0;
	logic [15:0] ea;
	sample_t     ed;

	assign errors = read_errs + write_errs;

	// Midpoint then sample for each input, previous sample zero at start
	function automatic void reference_words(input logic [15:0] dst);
		sample_t prev;
		int      s;
		prev = '0;
		for (int i = 0; i < src_q.size(); i++) begin
			s = int'(prev) + int'(src_q[i]);
			exp_addr.push_back(dst + 16'(2 * i));
			exp_data.push_back(sample_t'(s >>> 1));
			exp_addr.push_back(dst + 16'(2 * i + 1));
			exp_data.push_back(src_q[i]);
			prev = src_q[i];
		end
		src_q.delete();
	endfunction

	task automatic add_source(input sample_t s);
		src_q.push_back(s);
	endtask

	task automatic expect_job(input logic [15:0] dst);
		reference_words(dst);
	endtask

	// All expected words must have been written by now
	task automatic finish_job();
		if (exp_addr.size() != 0) begin
			read_errs++;
			$display("Job ended with %0d destination writes missing at %0t",
				exp_addr.size(), $time);
			exp_addr.delete();
			exp_data.delete();
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		if (got !== exp) begin
			read_errs++;
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, got);
		end
	endtask

	// Write port is stable by the falling edge
	always @(negedge clk) begin
		if (rst_n && mem_wr.en) begin
			if (exp_addr.size() == 0) begin
				write_errs++;
				$display("Unexpected destination write to %h at %0t", mem_wr.addr, $time);
			end else begin
				ea = exp_addr.pop_front();
				ed = exp_data.pop_front();
				if (mem_wr.addr !== ea) begin
					write_errs++;
					$display("FAILED at %0t: mem_wr.addr expected %h, got %h",
						$time, ea, mem_wr.addr);
				end
				if (mem_wr.data !== ed) begin
					write_errs++;
					$display("FAILED at %0t: mem_wr.data expected %h, got %h",
						$time, ed, mem_wr.data);
				end
			end
		end
	end

	task automatic print_summary(input int unsigned assert_errs);
		$display("Error count: read-back %0d, destination writes %0d, assertions %0d",
			read_errs, write_errs, assert_errs);
	endtask

endmodule

/* bench/upsampler_checker.sv */
`timescale 1ns/10ps

module upsampler_checker (
	input logic clk,
	input logic rst_n,
	input logic s_axi_bvalid,
	input logic s_axi_bready,
	input logic s_axi_rvalid,
	input logic s_axi_rready,
	input logic s_axi_awready,
	input logic s_axi_wready,
	input logic wbusy
);

	// Count of failed assertions
	int unsigned fail_cnt = 0;

	// Write response held until taken
	bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
		else begin
			$error("bvalid dropped before bready");
			fail_cnt++;
		end

	// Read data held until taken
	rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid)
		else begin
			$error("rvalid dropped before rready");
			fail_cnt++;
		end

	// Address and data accepted together
	aw_w_same: assert property (@(posedge clk) disable iff (!rst_n)
		s_axi_awready == s_axi_wready)
		else begin
			$error("awready and wready differ");
			fail_cnt++;
		end

	// PL port blocked one cycle at most
	wbusy_short: assert property (@(posedge clk) disable iff (!rst_n)
		wbusy |=> !wbusy)
		else begin
			$error("wbusy high for more than one cycle");
			fail_cnt++;
		end

endmodule

bind config_register_file upsampler_checker u_chk (
	.clk(clk), .rst_n(rst_n),
	.s_axi_bvalid(s_axi_bvalid), .s_axi_bready(s_axi_bready),
	.s_axi_rvalid(s_axi_rvalid), .s_axi_rready(s_axi_rready),
	.s_axi_awready(s_axi_awready), .s_axi_wready(s_axi_wready),
	.wbusy(wbusy)
);

/* bench/tb_upsampler.sv */
`timescale 1ns/10ps

module tb_upsampler import upsample_pkg::*; ();

	logic        clk;
	logic        rst_n;
	logic        s_axi_awvalid;
	logic        s_axi_awready;
	logic [31:0] s_axi_awaddr;
	logic [2:0]  s_axi_awprot;
	logic        s_axi_wvalid;
	logic        s_axi_wready;
	logic [31:0] s_axi_wdata;
	logic [3:0]  s_axi_wstrb;
	logic        s_axi_bvalid;
	logic        s_axi_bready;
	logic [1:0]  s_axi_bresp;
	logic        s_axi_arvalid;
	logic        s_axi_arready;
	logic [31:0] s_axi_araddr;
	logic [2:0]  s_axi_arprot;
	logic        s_axi_rvalid;
	logic        s_axi_rready;
	logic [31:0] s_axi_rdata;
	logic [1:0]  s_axi_rresp;
	logic        irq;
	logic        mem_rd_en;
	logic [15:0] mem_rd_addr;
	sample_t     mem_rd_data = '0;
	mem_wr_t     mem_wr;
	int          errors;
	// Sample memory and its one cycle read pipe
	sample_t     mem [65536];
	logic        rd_pend;
	logic [15:0] rd_addr_q;
	int unsigned limit_cycles = 0;

	upsampler_top DUT (.*);

	up_monitor mon (.clk(clk), .rst_n(rst_n), .mem_wr(mem_wr), .errors(errors));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Read data valid for the whole cycle after mem_rd_en
	always @(posedge clk) begin
		rd_pend   <= mem_rd_en;
		rd_addr_q <= mem_rd_addr;
	end
	always @(negedge clk) begin
		mem_rd_data <= rd_pend ? mem[rd_addr_q] : '0;
	end

	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
		int unsigned d;
		d = $urandom_range(3, 0);
		@(negedge clk);
		s_axi_awaddr  = addr;
		s_axi_wdata   = data;
		s_axi_awvalid = 1'b1;
		s_axi_wvalid  = 1'b1;
		while (!(s_axi_awready && s_axi_wready)) @(negedge clk);
		@(negedge clk);
		s_axi_awvalid = 1'b0;
		s_axi_wvalid  = 1'b0;
		// Random bready stall
		repeat (d) @(negedge clk);
		while (!s_axi_bvalid) @(negedge clk);
		mon.check_value("s_axi_bresp", 32'd0, {30'd0, s_axi_bresp});
		s_axi_bready = 1'b1;
		@(negedge clk);
		s_axi_bready = 1'b0;
	endtask

	task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
		int unsigned d;
		d = $urandom_range(3, 0);
		@(negedge clk);
		s_axi_araddr  = addr;
		s_axi_arvalid = 1'b1;
		while (!s_axi_arready) @(negedge clk);
		@(negedge clk);
		s_axi_arvalid = 1'b0;
		repeat (d) @(negedge clk);
		while (!s_axi_rvalid) @(negedge clk);
		data = s_axi_rdata;
		mon.check_value("s_axi_rresp", 32'd0, {30'd0, s_axi_rresp});
		s_axi_rready = 1'b1;
		@(negedge clk);
		s_axi_rready = 1'b0;
	endtask

	task automatic run_job(input logic [15:0] src, input logic [15:0] dst,
		input int unsigned cnt);
		logic [31:0] rd;
		for (int i = 0; i < cnt; i++) begin
			mon.add_source(mem[src + 16'(i)]);
		end
		mon.expect_job(dst);
		// Upper address bits are don't care
		axi_write(32'h8, {16'($urandom()), src});
		axi_write(32'hC, {16'($urandom()), dst});
		axi_write(32'h0, {20'h0, cnt[10:0], 1'b1});
		while (!irq) @(negedge clk);
		mon.finish_job();
		axi_read(32'h0, rd);
		mon.check_value("UPSTR", 32'd0, rd);
		axi_read(32'h4, rd);
		mon.check_value("UPENDR", 32'd1, rd);
		axi_write(32'h4, 32'd0);
		@(negedge clk);
		mon.check_value("irq", 32'd0, {31'd0, irq});
	endtask

	initial begin
		int unsigned counts [6];
		logic [31:0] exp_regs [4];
		logic [31:0] rd;
		void'($urandom(32'hc563_2020));
		rst_n         = 1'b0;
		s_axi_awvalid = 1'b0;
		s_axi_awaddr  = '0;
		s_axi_awprot  = '0;
		s_axi_wvalid  = 1'b0;
		s_axi_wdata   = '0;
		s_axi_wstrb   = 4'hF;
		s_axi_bready  = 1'b0;
		s_axi_arvalid = 1'b0;
		s_axi_araddr  = '0;
		s_axi_arprot  = '0;
		s_axi_rready  = 1'b0;
		for (int i = 0; i < 65536; i++) begin
			mem[i] = sample_t'($urandom());
		end
		// Fixed short job, empty job, then random lengths
		counts[0] = 5;
		counts[1] = 0;
		for (int i = 2; i < 6; i++) begin
			counts[i] = $urandom_range(40, 1);
		end
		limit_cycles = 2000;
		for (int i = 0; i < 6; i++) begin
			limit_cycles += 4 * counts[i];
		end
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Register read-back, go bit kept low
		exp_regs[0] = 32'h0001_FF00;
		exp_regs[1] = 32'hA5A5_0F0E;
		exp_regs[2] = 32'h1234_5678;
		exp_regs[3] = 32'h8765_4321;
		for (int i = 0; i < 4; i++) begin
			axi_write(32'(i * 4), exp_regs[i]);
		end
		for (int i = 0; i < 4; i++) begin
			axi_read(32'(i * 4), rd);
			mon.check_value($sformatf("reg%0d", i), exp_regs[i], rd);
		end
		// Unmapped space
		axi_write(32'h10, 32'hFFFF_FFFF);
		axi_write(32'h100, 32'hFFFF_FFFF);
		axi_read(32'h10, rd);
		mon.check_value("rdata at 0x10", 32'd0, rd);
		axi_read(32'h100, rd);
		mon.check_value("rdata at 0x100", 32'd0, rd);
		for (int i = 0; i < 4; i++) begin
			axi_read(32'(i * 4), rd);
			mon.check_value($sformatf("reg%0d after unmapped", i), exp_regs[i], rd);
		end
		mon.check_value("irq", 32'd0, {31'd0, irq});
		axi_write(32'h0, 32'd0);

		for (int i = 0; i < 6; i++) begin
			run_job(16'($urandom()), 16'($urandom()), counts[i]);
		end

		repeat (4) @(negedge clk);
		mon.print_summary(DUT.u_crf.u_chk.fail_cnt);
		if (errors == 0 && DUT.u_crf.u_chk.fail_cnt == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge clk);
		$display("Timeout, run did not finish within %0d cycles", limit_cycles);
		$display("Something failed");
		$finish;
	end

endmodule

/* compile.f */
hdl/upsample_pkg.sv
hdl/config_register_file.sv
hdl/upsample_ctrl.sv
hdl/interp_stage.sv
hdl/store_stage.sv
hdl/upsampler_top.sv
bench/up_monitor.sv
bench/upsampler_checker.sv
bench/tb_upsampler.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the log

rm -f sim.log && \
verilator --binary --assert --top-module tb_upsampler -f compile.f -o sim_upsampler && \
./obj_dir/sim_upsampler | tee sim.log

grep -q "^Everything OK$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
